/* design/floo_la_macros.svh */
// project-wide sizes for the look-ahead switch-allocation stage
// the mesh spans two to the power of each coordinate width and FLOO_NUM_VC must
// equal two to the power of FLOO_VC_IDX_W, since wraparound relies on overflow
`ifndef FLOO_LA_MACROS_SVH
`define FLOO_LA_MACROS_SVH

// virtual channels per input port and the width of a vc index
`define FLOO_NUM_VC 4
`define FLOO_VC_IDX_W 2

// 8 by 8 mesh
`define FLOO_X_W 3
`define FLOO_Y_W 3

// each local port of a node gets its own eject direction
`define FLOO_NUM_LOCAL 2
`define FLOO_LOCAL_IDX_W 1

// wide enough for the four mesh directions plus all eject ports
`define FLOO_DIR_W 3

`endif

/* design/floo_la_pkg.sv */
// route direction type shared by arbiter, routing, merge and top
// eject for local port k is encoded as Eject + k and is not an enum member
`default_nettype none

`include "floo_la_macros.svh"

package floo_la_pkg;

  // north raises y, east raises x
  typedef enum logic [`FLOO_DIR_W-1:0] {
    North = `FLOO_DIR_W'(0),
    East  = `FLOO_DIR_W'(1),
    South = `FLOO_DIR_W'(2),
    West  = `FLOO_DIR_W'(3),
    Eject = `FLOO_DIR_W'(4)
  } route_direction_e;

endpackage

`default_nettype wire

/* design/floo_vc_rr_arbiter.sv */
// round-robin pick of one valid vc, grant is combinational
// pointer wraps by overflow so the vc count must be a power of two
`timescale 1ns/1ps
`default_nettype none

`include "floo_la_macros.svh"

module floo_vc_rr_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`FLOO_NUM_VC-1:0] vc_valid_i,
  output logic [`FLOO_NUM_VC-1:0] grant_onehot_o
);

  // vc that currently holds the highest priority
  logic [`FLOO_VC_IDX_W-1:0] ptr_q;
  logic [`FLOO_VC_IDX_W-1:0] cand;
  logic [`FLOO_VC_IDX_W-1:0] grant_idx;
  logic                      found;

  // circular search starting at the pointer
  always_comb begin
    grant_onehot_o = '0;
    grant_idx      = ptr_q;
    found          = 1'b0;
    cand           = ptr_q;
    for (int i = 0; i < `FLOO_NUM_VC; i++) begin
      cand = ptr_q + `FLOO_VC_IDX_W'(i);
      if (!found && vc_valid_i[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
    if (found) begin
      grant_onehot_o[grant_idx] = 1'b1;
    end
  end

  // winner drops to lowest priority, pointer holds while idle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= grant_idx + `FLOO_VC_IDX_W'(1);
    end
  end

endmodule

`default_nettype wire

/* design/floo_look_ahead_routing.sv */
// per-vc look-ahead: step to the next node, then route xy from there
// coordinates wrap modulo the mesh size, eject directions do not move the node
`timescale 1ns/1ps
`default_nettype none

`include "floo_la_macros.svh"

module floo_look_ahead_routing
  import floo_la_pkg::*;
(
  input  logic [`FLOO_X_W-1:0]         node_x_i,
  input  logic [`FLOO_Y_W-1:0]         node_y_i,
  input  logic [`FLOO_X_W-1:0]         vc_dst_x_i    [`FLOO_NUM_VC],
  input  logic [`FLOO_Y_W-1:0]         vc_dst_y_i    [`FLOO_NUM_VC],
  input  logic [`FLOO_LOCAL_IDX_W-1:0] vc_dst_port_i [`FLOO_NUM_VC],
  input  route_direction_e             vc_la_dir_i   [`FLOO_NUM_VC],
  output route_direction_e             next_la_dir_o [`FLOO_NUM_VC]
);

  for (genvar v = 0; v < `FLOO_NUM_VC; v++) begin : gen_vc

    // coordinate of the router this head reaches next
    logic [`FLOO_X_W-1:0] nxt_x;
    logic [`FLOO_Y_W-1:0] nxt_y;

    always_comb begin
      nxt_x = node_x_i;
      nxt_y = node_y_i;
      case (vc_la_dir_i[v])
        North: begin
          nxt_y = node_y_i + `FLOO_Y_W'(1);
        end
        South: begin
          nxt_y = node_y_i - `FLOO_Y_W'(1);
        end
        East: begin
          nxt_x = node_x_i + `FLOO_X_W'(1);
        end
        West: begin
          nxt_x = node_x_i - `FLOO_X_W'(1);
        end
        default: begin
          // ejecting here, next node is this node
        end
      endcase
    end

    // dimension order, x is resolved before y
    always_comb begin
      if (vc_dst_x_i[v] > nxt_x) begin
        next_la_dir_o[v] = East;
      end else if (vc_dst_x_i[v] < nxt_x) begin
        next_la_dir_o[v] = West;
      end else if (vc_dst_y_i[v] > nxt_y) begin
        next_la_dir_o[v] = North;
      end else if (vc_dst_y_i[v] < nxt_y) begin
        next_la_dir_o[v] = South;
      end else begin
        // arrived, pick the eject port of the destination local port
        next_la_dir_o[v] = route_direction_e'(Eject + `FLOO_DIR_W'(vc_dst_port_i[v]));
      end
    end

  end

endmodule

`default_nettype wire

/* design/floo_sa_local_merge.sv */
// turns the one-hot grant into a registered allocation result
// grant must be one-hot or zero, the lowest set bit wins otherwise
`timescale 1ns/1ps
`default_nettype none

`include "floo_la_macros.svh"

module floo_sa_local_merge
  import floo_la_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`FLOO_NUM_VC-1:0]   grant_onehot_i,
  input  route_direction_e          next_la_dir_i [`FLOO_NUM_VC],
  input  route_direction_e          vc_la_dir_i   [`FLOO_NUM_VC],
  output logic                      sa_valid_o,
  output logic [`FLOO_VC_IDX_W-1:0] sa_vc_o,
  output route_direction_e          sa_out_dir_o,
  output route_direction_e          sa_next_la_dir_o
);

  logic [`FLOO_VC_IDX_W-1:0] grant_idx;
  logic                      any_grant;
  route_direction_e          sel_out_dir;
  route_direction_e          sel_next_dir;

  logic                      valid_q;
  logic [`FLOO_VC_IDX_W-1:0] vc_q;
  route_direction_e          out_dir_q;
  route_direction_e          next_dir_q;

  // one-hot to index, scanned from the top so vc 0 ends last
  always_comb begin
    grant_idx = '0;
    for (int i = `FLOO_NUM_VC - 1; i >= 0; i--) begin
      if (grant_onehot_i[i]) begin
        grant_idx = `FLOO_VC_IDX_W'(i);
      end
    end
  end

  assign any_grant = |grant_onehot_i;

  // out dir is this router's port, next dir goes into the header
  assign sel_out_dir  = vc_la_dir_i[grant_idx];
  assign sel_next_dir = next_la_dir_i[grant_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q    <= 1'b0;
      vc_q       <= '0;
      out_dir_q  <= North;
      next_dir_q <= North;
    end else begin
      valid_q <= any_grant;
      // result fields keep the last grant while idle
      if (any_grant) begin
        vc_q       <= grant_idx;
        out_dir_q  <= sel_out_dir;
        next_dir_q <= sel_next_dir;
      end
    end
  end

  assign sa_valid_o       = valid_q;
  assign sa_vc_o          = vc_q;
  assign sa_out_dir_o     = out_dir_q;
  assign sa_next_la_dir_o = next_dir_q;

endmodule

`default_nettype wire

/* design/floo_sa_local_port.sv */
// local switch allocation of one input port, one cycle from heads to result
// no back-pressure, the granted flit is assumed to leave its vc at once
`timescale 1ns/1ps
`default_nettype none

`include "floo_la_macros.svh"

module floo_sa_local_port
  import floo_la_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [`FLOO_X_W-1:0]         node_x_i,
  input  logic [`FLOO_Y_W-1:0]         node_y_i,
  input  logic [`FLOO_NUM_VC-1:0]      vc_valid_i,
  input  logic [`FLOO_X_W-1:0]         vc_dst_x_i    [`FLOO_NUM_VC],
  input  logic [`FLOO_Y_W-1:0]         vc_dst_y_i    [`FLOO_NUM_VC],
  input  logic [`FLOO_LOCAL_IDX_W-1:0] vc_dst_port_i [`FLOO_NUM_VC],
  input  route_direction_e             vc_la_dir_i   [`FLOO_NUM_VC],
  output logic                         sa_valid_o,
  output logic [`FLOO_VC_IDX_W-1:0]    sa_vc_o,
  output route_direction_e             sa_out_dir_o,
  output route_direction_e             sa_next_la_dir_o
);

  logic [`FLOO_NUM_VC-1:0] grant_onehot;
  route_direction_e        next_la_dir [`FLOO_NUM_VC];

  floo_vc_rr_arbiter i_vc_rr_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .vc_valid_i     (vc_valid_i),
    .grant_onehot_o (grant_onehot)
  );

  // routing runs for every head in parallel with arbitration
  floo_look_ahead_routing i_look_ahead_routing (
    .node_x_i      (node_x_i),
    .node_y_i      (node_y_i),
    .vc_dst_x_i    (vc_dst_x_i),
    .vc_dst_y_i    (vc_dst_y_i),
    .vc_dst_port_i (vc_dst_port_i),
    .vc_la_dir_i   (vc_la_dir_i),
    .next_la_dir_o (next_la_dir)
  );

  floo_sa_local_merge i_sa_local_merge (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .grant_onehot_i   (grant_onehot),
    .next_la_dir_i    (next_la_dir),
    .vc_la_dir_i      (vc_la_dir_i),
    .sa_valid_o       (sa_valid_o),
    .sa_vc_o          (sa_vc_o),
    .sa_out_dir_o     (sa_out_dir_o),
    .sa_next_la_dir_o (sa_next_la_dir_o)
  );

endmodule

`default_nettype wire

/* bench/floo_sa_local_tb.sv */
// file-driven testbench for the local switch-allocation stage
// run from the project root so bench/sa_local_input.txt resolves
// random idle gaps between vectors leave the arbiter pointer untouched
`timescale 1ns/1ps
`default_nettype none

`include "floo_la_macros.svh"

module floo_sa_local_tb
  import floo_la_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int MAX_VEC    = 64;
  localparam int MAX_GAP    = 2;
  // node x, node y, five fields per vc, then four expected outputs
  localparam int EXP_BASE   = 2 + 5 * `FLOO_NUM_VC;
  localparam int NUM_FIELDS = EXP_BASE + 4;

  logic                         clk_i;
  logic                         rst_i;
  logic [`FLOO_X_W-1:0]         node_x_i;
  logic [`FLOO_Y_W-1:0]         node_y_i;
  logic [`FLOO_NUM_VC-1:0]      vc_valid_i;
  logic [`FLOO_X_W-1:0]         vc_dst_x_i    [`FLOO_NUM_VC];
  logic [`FLOO_Y_W-1:0]         vc_dst_y_i    [`FLOO_NUM_VC];
  logic [`FLOO_LOCAL_IDX_W-1:0] vc_dst_port_i [`FLOO_NUM_VC];
  route_direction_e             vc_la_dir_i   [`FLOO_NUM_VC];
  logic                         sa_valid_o;
  logic [`FLOO_VC_IDX_W-1:0]    sa_vc_o;
  route_direction_e             sa_out_dir_o;
  route_direction_e             sa_next_la_dir_o;

  int     vec_mem [MAX_VEC][NUM_FIELDS];
  int     gap_len [MAX_VEC];
  int     num_vec;
  int     gap_total;
  int     errors;
  int     checks;
  bit     stim_loaded;
  longint watchdog_ns;

  floo_sa_local_port floo_sa_local_port_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .node_x_i         (node_x_i),
    .node_y_i         (node_y_i),
    .vc_valid_i       (vc_valid_i),
    .vc_dst_x_i       (vc_dst_x_i),
    .vc_dst_y_i       (vc_dst_y_i),
    .vc_dst_port_i    (vc_dst_port_i),
    .vc_la_dir_i      (vc_la_dir_i),
    .sa_valid_o       (sa_valid_o),
    .sa_vc_o          (sa_vc_o),
    .sa_out_dir_o     (sa_out_dir_o),
    .sa_next_la_dir_o (sa_next_la_dir_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // limit grows with the vector count and the drawn idle gaps
  initial begin
    wait (stim_loaded);
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("Test failures found");
    $finish;
  end

  task automatic init_inputs();
    int v;
    rst_i      = 1'b1;
    node_x_i   = '0;
    node_y_i   = '0;
    vc_valid_i = '0;
    for (v = 0; v < `FLOO_NUM_VC; v++) begin
      vc_dst_x_i[v]    = '0;
      vc_dst_y_i[v]    = '0;
      vc_dst_port_i[v] = '0;
      vc_la_dir_i[v]   = North;
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    ch;
    int    k;
    bit    bad;
    string tok;
    fd = $fopen("bench/sa_local_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open stimulus file bench/sa_local_input.txt");
      errors++;
      return;
    end
    bad = 1'b0;
    while (!bad) begin
      code = $fscanf(fd, " %s", tok);
      if (code != 1) begin
        break;
      end
      if (tok.getc(0) == "#") begin
        // comment, skip the rest of the line
        ch = 0;
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if (num_vec >= MAX_VEC) begin
        $display("ERROR: stimulus file holds more than %0d vectors", MAX_VEC);
        errors++;
        bad = 1'b1;
      end else begin
        vec_mem[num_vec][0] = tok.atoi();
        for (k = 1; k < NUM_FIELDS; k++) begin
          code = $fscanf(fd, "%d", vec_mem[num_vec][k]);
          if (code != 1 && !bad) begin
            $display("ERROR: stimulus vector %0d has too few fields", num_vec);
            errors++;
            bad = 1'b1;
          end
        end
        if (!bad) begin
          num_vec++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    vc_valid_i = '0;
  endtask

  task automatic drive_vector(int n);
    int v;
    int base;
    node_x_i = `FLOO_X_W'(vec_mem[n][0]);
    node_y_i = `FLOO_Y_W'(vec_mem[n][1]);
    for (v = 0; v < `FLOO_NUM_VC; v++) begin
      base             = 2 + 5 * v;
      vc_valid_i[v]    = (vec_mem[n][base] != 0);
      vc_dst_x_i[v]    = `FLOO_X_W'(vec_mem[n][base + 1]);
      vc_dst_y_i[v]    = `FLOO_Y_W'(vec_mem[n][base + 2]);
      vc_dst_port_i[v] = `FLOO_LOCAL_IDX_W'(vec_mem[n][base + 3]);
      vc_la_dir_i[v]   = route_direction_e'(`FLOO_DIR_W'(vec_mem[n][base + 4]));
    end
  endtask

  task automatic compare_field(string where, string what, int got, int exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED time=%0t %s: %s got %0d expected %0d",
               $time, where, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_vector(int n);
    string where;
    where = $sformatf("vector %0d", n);
    compare_field(where, "sa_valid_o", int'(sa_valid_o), vec_mem[n][EXP_BASE]);
    compare_field(where, "sa_vc_o", int'(sa_vc_o), vec_mem[n][EXP_BASE + 1]);
    compare_field(where, "sa_out_dir_o", int'(sa_out_dir_o), vec_mem[n][EXP_BASE + 2]);
    compare_field(where, "sa_next_la_dir_o", int'(sa_next_la_dir_o), vec_mem[n][EXP_BASE + 3]);
  endtask

  initial begin
    int n;
    int g;
    errors      = 0;
    checks      = 0;
    num_vec     = 0;
    gap_total   = 0;
    stim_loaded = 1'b0;
    init_inputs();
    void'($urandom(32'ha8d0_a93d));

    load_vectors();
    for (n = 0; n < num_vec; n++) begin
      gap_len[n] = int'($urandom % (MAX_GAP + 1));
      gap_total  = gap_total + gap_len[n];
    end
    watchdog_ns = longint'(num_vec * 20 + gap_total + 10) * CLK_PERIOD;
    stim_loaded = 1'b1;

    // two rising edges in reset, released on a falling edge
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (n = 0; n < num_vec; n++) begin
      for (g = 0; g < gap_len[n]; g++) begin
        drive_idle();
        @(posedge clk_i);
        #2;
        compare_field($sformatf("idle before vector %0d", n), "sa_valid_o",
                      int'(sa_valid_o), 0);
        @(negedge clk_i);
      end
      drive_vector(n);
      @(posedge clk_i);
      #2;
      check_vector(n);
      @(negedge clk_i);
    end

    $display("vectors: %0d, checks run: %0d, errors: %0d", num_vec, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/floo_la_pkg.sv
design/floo_vc_rr_arbiter.sv
design/floo_look_ahead_routing.sv
design/floo_sa_local_merge.sv
design/floo_sa_local_port.sv
bench/floo_sa_local_tb.sv

/* run_verilator.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
# run from any directory, all paths are taken relative to this script

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module floo_sa_local_tb \
  -o sim_floo_sa_local > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_floo_sa_local > "$LOG" 2>&1 || { cat "$LOG"; echo "simulation aborted"; exit 1; }

cat "$LOG"
grep -q "Test failures found" "$LOG" && { echo "RESULT: FAIL"; exit 1; } || { echo "RESULT: PASS"; exit 0; }

/* bench/sa_local_input.txt */
# columns: node_x node_y, then per vc 0..3: valid dst_x dst_y dst_port la_dir,
# then expected sa_valid sa_vc sa_out_dir sa_next_la_dir (dir N=0 E=1 S=2 W=3 Eject=4+port)
# idle after reset, outputs stay at zero
3 3  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0
3 3  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0
# all four valid, round robin 0 1 2 3 0, one step in each direction
3 3  1 5 3 0 1  1 3 6 1 0  1 1 3 0 3  1 3 0 1 2  1 0 1 1
3 3  1 5 3 0 1  1 3 6 1 0  1 1 3 0 3  1 3 0 1 2  1 1 0 0
3 3  1 5 3 0 1  1 3 6 1 0  1 1 3 0 3  1 3 0 1 2  1 2 3 3
3 3  1 5 3 0 1  1 3 6 1 0  1 1 3 0 3  1 3 0 1 2  1 3 2 2
3 3  1 5 3 0 1  1 3 6 1 0  1 1 3 0 3  1 3 0 1 2  1 0 1 1
# x resolved before y
2 2  0 0 0 0 0  1 0 6 0 0  0 0 0 0 0  0 0 0 0 0  1 1 0 3
# sparse valid sets, first valid at or after the pointer
2 2  1 2 2 0 4  0 0 0 0 0  0 0 0 0 0  1 5 0 0 2  1 3 2 1
2 2  1 2 2 0 4  0 0 0 0 0  0 0 0 0 0  1 5 0 0 2  1 0 4 4
2 2  1 2 2 0 4  0 0 0 0 0  1 3 2 1 1  0 0 0 0 0  1 2 1 5
2 2  1 2 2 1 5  0 0 0 0 0  1 3 2 1 1  0 0 0 0 0  1 0 5 5
# wraparound at the mesh edge
7 4  0 0 0 0 0  1 0 6 0 1  0 0 0 0 0  0 0 0 0 0  1 1 1 0
0 5  0 0 0 0 0  0 0 0 0 0  1 6 5 0 3  0 0 0 0 0  1 2 3 3
4 7  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 4 2 1 0  1 3 0 0
4 0  0 0 0 0 0  1 4 5 0 2  0 0 0 0 0  0 0 0 0 0  1 1 2 2
# no request, result fields hold the last grant
4 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 1 2 2
# all valid again from pointer 2, mixes eject and mesh routes
6 1  1 6 1 1 3  1 6 2 0 0  1 7 1 1 1  1 0 0 0 2  1 2 1 5
6 1  1 6 1 1 3  1 6 2 0 0  1 7 1 1 1  1 0 0 0 2  1 3 2 3
6 1  1 6 1 1 3  1 6 2 0 0  1 7 1 1 1  1 0 0 0 2  1 0 3 1
6 1  1 6 1 1 3  1 6 2 0 0  1 7 1 1 1  1 0 0 0 2  1 1 0 4
1 1  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 4 0 3  1 3 3 0
# eject look-ahead routes from the unchanged node
1 1  0 0 0 0 0  1 1 0 1 4  1 1 2 1 0  0 0 0 0 0  1 1 4 2
1 1  0 0 0 0 0  1 1 0 1 4  1 1 2 1 0  0 0 0 0 0  1 2 0 5
1 1  0 0 0 0 0  1 1 0 1 4  1 1 2 1 0  0 0 0 0 0  1 1 4 2
# south step wraps y from 0 to 7
0 0  1 0 3 0 2  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 2 2
